// File: rtl/apb_ss_pkg.sv
// ======================================================================
// Shared address map, register offsets and bus types of the subsystem
// Word transfers only, no bursts, no byte lanes
// Address bits 11:8 pick the peripheral, bits 7:2 the register
// ======================================================================

package apb_ss_pkg;

  // ====================================================================
  // Bus widths
  // ====================================================================
  localparam int DATA_W = 32;              // AHB and APB data
  localparam int ADDR_W = 32;              // AHB address
  localparam int GPIO_W = 16;              // Pin count

  // Slot values of haddr[11:8]
  localparam logic [3:0] SLOT_TIMER = 4'd0;
  localparam logic [3:0] SLOT_GPIO  = 4'd1; // Anything else is unmapped

  // ====================================================================
  // Register word offsets, paddr[7:2]
  // ====================================================================
  // Timer
  localparam logic [5:0] TMR_CTRL   = 6'd0; // [0] run, [1] irq enable
  localparam logic [5:0] TMR_LOAD   = 6'd1; // 16-bit reload
  localparam logic [5:0] TMR_COUNT  = 6'd2; // Read only
  localparam logic [5:0] TMR_STATUS = 6'd3; // [0] expired, W1C

  // GPIO
  localparam logic [5:0] GPIO_OUT    = 6'd0;
  localparam logic [5:0] GPIO_DIR    = 6'd1; // 1 = output
  localparam logic [5:0] GPIO_IN     = 6'd2; // Synchronized levels
  localparam logic [5:0] GPIO_IRQ_EN = 6'd3;
  localparam logic [5:0] GPIO_IRQ_ST = 6'd4; // Pending flags, W1C

  // ====================================================================
  // Enums
  // ====================================================================
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Bridge FSM
  typedef enum logic [2:0] {
    ST_IDLE,                               // Ready for an address phase
    ST_SETUP,                              // APB setup, psel only
    ST_ACCESS,                             // APB access, penable high
    ST_ERR1,                               // ERROR, hready low
    ST_ERR2                                // ERROR, hready high
  } bridge_state_e;

  // ====================================================================
  // Bus structs
  // ====================================================================
  // AHB address phase
  typedef struct packed {
    logic [ADDR_W-1:0] haddr;
    htrans_e           htrans;
    logic              hwrite;
    logic              hsel;               // Slave select from the AHB decoder
  } ahb_req_t;

  // APB request, shared by all slaves; selects travel separately
  typedef struct packed {
    logic [7:0]        paddr;
    logic              pwrite;
    logic              penable;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

endpackage

// File: rtl/ahb2apb_bridge.sv
// ======================================================================
// AHB-lite to APB bridge for single word transfers
// Each mapped transfer costs two APB cycles plus one to return data
// Unmapped slots get the two-cycle ERROR response, read data is zero
// PREADY is not modelled, APB runs on the AHB clock
// ======================================================================

module ahb2apb_bridge (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_hsel,
  input  apb_ss_pkg::ahb_req_t              i_ahb,
  input  logic [apb_ss_pkg::DATA_W-1:0]     i_hwdata,
  input  logic [apb_ss_pkg::DATA_W-1:0]     i_prdata_timer,
  input  logic [apb_ss_pkg::DATA_W-1:0]     i_prdata_gpio,
  output apb_ss_pkg::apb_req_t              o_apb,
  output logic                              o_psel_timer,
  output logic                              o_psel_gpio,
  output logic [apb_ss_pkg::DATA_W-1:0]     o_hrdata,
  output logic                              o_hready,
  output apb_ss_pkg::hresp_e                o_hresp
);

  apb_ss_pkg::bridge_state_e             state_q, state_d;
  logic [11:0]                           addr_q;      // Slot and register bits only
  logic                                  write_q;
  logic [apb_ss_pkg::DATA_W-1:0]         pwdata_q;
  logic [apb_ss_pkg::DATA_W-1:0]         hrdata_q;
  logic [apb_ss_pkg::DATA_W-1:0]         prdata_sel;
  logic [3:0]                            slot_in;
  logic                                  xfer_valid;
  logic                                  mapped;
  logic                                  accept;
  logic                                  apb_phase;

  // ====================================================================
  // Address phase decode
  // ====================================================================
  assign slot_in = i_ahb.haddr[11:8];

  // Both the subsystem select and the decoder select must be up
  assign xfer_valid = i_hsel && i_ahb.hsel &&
                      (i_ahb.htrans == apb_ss_pkg::NONSEQ ||
                       i_ahb.htrans == apb_ss_pkg::SEQ);    // IDLE, BUSY ignored

  assign mapped = (slot_in == apb_ss_pkg::SLOT_TIMER) ||
                  (slot_in == apb_ss_pkg::SLOT_GPIO);

  // hready high in IDLE and in the last ERROR cycle
  assign o_hready = (state_q == apb_ss_pkg::ST_IDLE) ||
                    (state_q == apb_ss_pkg::ST_ERR2);
  assign accept   = o_hready && xfer_valid;

  assign o_hresp = (state_q == apb_ss_pkg::ST_ERR1 || state_q == apb_ss_pkg::ST_ERR2) ?
                   apb_ss_pkg::ERROR : apb_ss_pkg::OKAY;

  // ====================================================================
  // FSM
  // ====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      apb_ss_pkg::ST_IDLE,
      apb_ss_pkg::ST_ERR2: begin
        if (accept) begin
          state_d = mapped ? apb_ss_pkg::ST_SETUP : apb_ss_pkg::ST_ERR1;
        end else begin
          state_d = apb_ss_pkg::ST_IDLE;
        end
      end
      apb_ss_pkg::ST_SETUP:  state_d = apb_ss_pkg::ST_ACCESS;
      apb_ss_pkg::ST_ACCESS: state_d = apb_ss_pkg::ST_IDLE;   // hready back up
      apb_ss_pkg::ST_ERR1:   state_d = apb_ss_pkg::ST_ERR2;
      default:               state_d = apb_ss_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q  <= apb_ss_pkg::ST_IDLE;
      hrdata_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == apb_ss_pkg::ST_ACCESS) begin
        hrdata_q <= write_q ? '0 : prdata_sel;              // Read data to AHB
      end else if (accept && !mapped) begin
        hrdata_q <= '0;                                     // Error reads zero
      end
    end
  end

  // Transfer attributes, held for the whole APB access
  always_ff @(posedge i_clk) begin
    if (accept) begin
      addr_q  <= i_ahb.haddr[11:0];
      write_q <= i_ahb.hwrite;
    end
    // Write data arrives in the AHB data phase
    if (state_q == apb_ss_pkg::ST_SETUP) begin
      pwdata_q <= i_hwdata;
    end
  end

  // ====================================================================
  // APB side
  // ====================================================================
  assign apb_phase = (state_q == apb_ss_pkg::ST_SETUP) ||
                     (state_q == apb_ss_pkg::ST_ACCESS);

  assign o_psel_timer = apb_phase && (addr_q[11:8] == apb_ss_pkg::SLOT_TIMER);
  assign o_psel_gpio  = apb_phase && (addr_q[11:8] == apb_ss_pkg::SLOT_GPIO);

  assign o_apb.paddr   = addr_q[7:0];
  assign o_apb.pwrite  = write_q;
  assign o_apb.penable = (state_q == apb_ss_pkg::ST_ACCESS);
  assign o_apb.pwdata  = pwdata_q;

  // Read mux, only one select is ever up
  assign prdata_sel = o_psel_timer ? i_prdata_timer :
                      o_psel_gpio  ? i_prdata_gpio  : '0;

  assign o_hrdata = hrdata_q;

endmodule

// File: rtl/apb_timer.sv
// ======================================================================
// Periodic 16-bit down-counter on APB
// Counts while enabled and non-zero; expiry reloads and sets the flag
// A write to the load register also loads the count
// Status flag is write-1-to-clear, a new expiry wins over the clear
// ======================================================================

module apb_timer (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_psel,
  input  apb_ss_pkg::apb_req_t              i_apb,
  output logic [apb_ss_pkg::DATA_W-1:0]     o_prdata,
  output logic                              o_irq
);

  logic [1:0]  ctrl_q;                     // [0] run, [1] irq enable
  logic [15:0] load_q;
  logic [15:0] count_q;
  logic        expired_q;
  logic [5:0]  reg_sel;
  logic        wr_en;
  logic        expire;

  assign reg_sel = i_apb.paddr[7:2];
  assign wr_en   = i_psel && i_apb.penable && i_apb.pwrite;

  // Last tick before zero, the count reloads instead
  assign expire = ctrl_q[0] && (count_q == 16'd1);

  // ====================================================================
  // Registers
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ctrl_q    <= '0;
      load_q    <= '0;
      count_q   <= '0;
      expired_q <= 1'b0;
    end else begin
      // Control
      if (wr_en && reg_sel == apb_ss_pkg::TMR_CTRL) begin
        ctrl_q <= i_apb.pwdata[1:0];
      end

      // Load and count
      if (wr_en && reg_sel == apb_ss_pkg::TMR_LOAD) begin
        load_q  <= i_apb.pwdata[15:0];
        count_q <= i_apb.pwdata[15:0];                      // Immediate load
      end else if (expire) begin
        count_q <= load_q;                                  // Periodic reload
      end else if (ctrl_q[0] && count_q != '0) begin
        count_q <= count_q - 16'd1;
      end

      // Expiry flag
      if (expire) begin
        expired_q <= 1'b1;
      end else if (wr_en && reg_sel == apb_ss_pkg::TMR_STATUS && i_apb.pwdata[0]) begin
        expired_q <= 1'b0;                                  // W1C
      end
    end
  end

  // ====================================================================
  // Read side
  // ====================================================================
  always_comb begin
    o_prdata = '0;
    if (i_psel) begin
      case (reg_sel)
        apb_ss_pkg::TMR_CTRL:   o_prdata = {30'd0, ctrl_q};
        apb_ss_pkg::TMR_LOAD:   o_prdata = {16'd0, load_q};
        apb_ss_pkg::TMR_COUNT:  o_prdata = {16'd0, count_q};
        apb_ss_pkg::TMR_STATUS: o_prdata = {31'd0, expired_q};
        default:                o_prdata = '0;              // Unused offsets
      endcase
    end
  end

  // Flag masked by the irq enable
  assign o_irq = expired_q && ctrl_q[1];

endmodule

// File: rtl/apb_gpio.sv
// ======================================================================
// 16-pin GPIO on APB
// Inputs go through a two-stage synchronizer before any use
// Rising edges always set pending flags; the mask only gates the irq
// Pins set as inputs drive 0 on the output bus
// ======================================================================

module apb_gpio (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_psel,
  input  apb_ss_pkg::apb_req_t                i_apb,
  input  logic [apb_ss_pkg::GPIO_W-1:0]       i_pin,
  output logic [apb_ss_pkg::GPIO_W-1:0]       o_pin_out,
  output logic [apb_ss_pkg::GPIO_W-1:0]       o_pin_oe,
  output logic [apb_ss_pkg::DATA_W-1:0]       o_prdata,
  output logic                                o_irq
);

  logic [apb_ss_pkg::GPIO_W-1:0] out_q;
  logic [apb_ss_pkg::GPIO_W-1:0] dir_q;
  logic [apb_ss_pkg::GPIO_W-1:0] irq_en_q;
  logic [apb_ss_pkg::GPIO_W-1:0] irq_st_q;
  logic [apb_ss_pkg::GPIO_W-1:0] sync1_q, sync2_q;   // Synchronizer
  logic [apb_ss_pkg::GPIO_W-1:0] prev_q;            // sync2 one cycle later
  logic [apb_ss_pkg::GPIO_W-1:0] rise;
  logic [apb_ss_pkg::GPIO_W-1:0] st_clr;
  logic [5:0]                    reg_sel;
  logic                          wr_en;

  assign reg_sel = i_apb.paddr[7:2];
  assign wr_en   = i_psel && i_apb.penable && i_apb.pwrite;

  assign rise   = sync2_q & ~prev_q;
  assign st_clr = (wr_en && reg_sel == apb_ss_pkg::GPIO_IRQ_ST) ?
                  i_apb.pwdata[apb_ss_pkg::GPIO_W-1:0] : '0;

  // ====================================================================
  // Registers and input path
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      out_q    <= '0;
      dir_q    <= '0;
      irq_en_q <= '0;
      irq_st_q <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
    end else begin
      sync1_q  <= i_pin;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      irq_st_q <= (irq_st_q & ~st_clr) | rise;      // Set beats clear
      if (wr_en) begin
        case (reg_sel)
          apb_ss_pkg::GPIO_OUT:    out_q    <= i_apb.pwdata[apb_ss_pkg::GPIO_W-1:0];
          apb_ss_pkg::GPIO_DIR:    dir_q    <= i_apb.pwdata[apb_ss_pkg::GPIO_W-1:0];
          apb_ss_pkg::GPIO_IRQ_EN: irq_en_q <= i_apb.pwdata[apb_ss_pkg::GPIO_W-1:0];
          default: ;                                // IN is read only
        endcase
      end
    end
  end

  // ====================================================================
  // Read side and outputs
  // ====================================================================
  always_comb begin
    o_prdata = '0;
    if (i_psel) begin
      case (reg_sel)
        apb_ss_pkg::GPIO_OUT:    o_prdata = {16'd0, out_q};
        apb_ss_pkg::GPIO_DIR:    o_prdata = {16'd0, dir_q};
        apb_ss_pkg::GPIO_IN:     o_prdata = {16'd0, sync2_q};
        apb_ss_pkg::GPIO_IRQ_EN: o_prdata = {16'd0, irq_en_q};
        apb_ss_pkg::GPIO_IRQ_ST: o_prdata = {16'd0, irq_st_q};
        default:                 o_prdata = '0;
      endcase
    end
  end

  assign o_pin_out = out_q & dir_q;                 // Inputs drive 0
  assign o_pin_oe  = dir_q;
  assign o_irq     = |(irq_st_q & irq_en_q);

endmodule

// File: rtl/apb_subsystem.sv
// ======================================================================
// Subsystem top, AHB-lite slave with a timer and a GPIO block behind
// Single clock and synchronous active-low reset for all blocks
// ======================================================================

module apb_subsystem (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_hsel,
  input  apb_ss_pkg::ahb_req_t              i_ahb,
  input  logic [apb_ss_pkg::DATA_W-1:0]     i_hwdata,
  input  logic [apb_ss_pkg::GPIO_W-1:0]     i_gpio_pin,
  output logic [apb_ss_pkg::DATA_W-1:0]     o_hrdata,
  output logic                              o_hready,
  output apb_ss_pkg::hresp_e                o_hresp,
  output logic [apb_ss_pkg::GPIO_W-1:0]     o_gpio_out,
  output logic [apb_ss_pkg::GPIO_W-1:0]     o_gpio_oe,
  output logic                              o_timer_irq,
  output logic                              o_gpio_irq
);

  // Shared APB request and per-slave returns
  apb_ss_pkg::apb_req_t              apb_req;
  logic                              psel_timer;
  logic                              psel_gpio;
  logic [apb_ss_pkg::DATA_W-1:0]     prdata_timer;
  logic [apb_ss_pkg::DATA_W-1:0]     prdata_gpio;

  ahb2apb_bridge bridge_i (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_hsel         (i_hsel),
    .i_ahb          (i_ahb),
    .i_hwdata       (i_hwdata),
    .i_prdata_timer (prdata_timer),
    .i_prdata_gpio  (prdata_gpio),
    .o_apb          (apb_req),
    .o_psel_timer   (psel_timer),
    .o_psel_gpio    (psel_gpio),
    .o_hrdata       (o_hrdata),
    .o_hready       (o_hready),
    .o_hresp        (o_hresp)
  );

  apb_timer timer_i (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_psel   (psel_timer),
    .i_apb    (apb_req),
    .o_prdata (prdata_timer),
    .o_irq    (o_timer_irq)
  );

  apb_gpio gpio_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_psel    (psel_gpio),
    .i_apb     (apb_req),
    .i_pin     (i_gpio_pin),
    .o_pin_out (o_gpio_out),
    .o_pin_oe  (o_gpio_oe),
    .o_prdata  (prdata_gpio),
    .o_irq     (o_gpio_irq)
  );

endmodule

// File: tb/ahb_master_tasks.svh
// ======================================================================
// AHB-lite master tasks, included inside the testbench top module
// One single word transfer at a time, each call starts 1 ns after an edge
// Uses the testbench signals and error counter directly
// ======================================================================
`ifndef AHB_MASTER_TASKS_SVH
`define AHB_MASTER_TASKS_SVH

// 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Address phase, then the data phase until hready comes back
task automatic single_transfer(input logic [31:0] addr, input logic wr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic resp);
  int waited;
  waited = 0;
  ahb_req.haddr  = addr;
  ahb_req.htrans = apb_ss_pkg::NONSEQ;
  ahb_req.hwrite = wr;
  ahb_req.hsel   = 1'b1;
  hsel           = 1'b1;
  @(posedge tb_hclk26);                    // Address sampled here
  #1;
  ahb_req.htrans = apb_ss_pkg::IDLE;       // No follow-on transfer
  ahb_req.hsel   = 1'b0;
  hsel           = 1'b0;
  hwdata         = wdata;                  // Data phase
  while (!hready && waited < 16) begin
    @(posedge tb_hclk26);
    #1;
    waited++;
  end
  assert (hready) else begin
    $display("No hready within 16 cycles for the transfer to %h", addr);
    errors++;
  end
  rdata = hrdata;
  resp  = hresp;
endtask

task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data, output logic resp);
  logic [31:0] unused_rdata;
  single_transfer(addr, 1'b1, data, unused_rdata, resp);
endtask

task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data, output logic resp);
  single_transfer(addr, 1'b0, 32'd0, data, resp);
endtask

// Stops early once the interrupt is seen; 1 = GPIO, 0 = timer
task automatic wait_irq(input logic which, input int limit, output logic seen);
  int n;
  n    = 0;
  seen = which ? gpio_irq : timer_irq;
  while (!seen && n < limit) begin
    @(posedge tb_hclk26);
    #1;
    n++;
    seen = which ? gpio_irq : timer_irq;
  end
endtask

`endif

// File: tb/apb_subsystem_tb.sv
// ======================================================================
// Testbench for the AHB-lite timer and GPIO subsystem
// Runs the operations of tb/apb_subsystem_stimulus.txt, run from the root
// Expected values come from the stimulus file and a small pin model
// All inputs change 1 ns after a rising edge
// ======================================================================

module apb_subsystem_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_OPS = 64;

  logic                 tb_hclk26 = 1'b0;
  logic                 hresetn26;
  logic                 hsel;
  apb_ss_pkg::ahb_req_t ahb_req;
  logic [31:0]          hwdata;
  logic [15:0]          gpio_pin;
  logic [31:0]          hrdata;
  logic                 hready;
  apb_ss_pkg::hresp_e   hresp;
  logic [15:0]          gpio_out, gpio_oe;
  logic                 timer_irq, gpio_irq;

  logic [7:0]  op_code [MAX_OPS];           // W R P I X
  logic [31:0] op_a [MAX_OPS];
  logic [31:0] op_b [MAX_OPS];
  logic [31:0] op_c [MAX_OPS];
  logic [31:0] op_d [MAX_OPS];
  int          n_ops = 0;
  int          budget = 0;                  // Watchdog cycles
  logic        budget_ready = 1'b0;
  int          errors = 0;
  logic [31:0] lcg_state;
  logic [15:0] model_out, model_dir;        // Last GPIO_OUT, GPIO_DIR written

  `include "ahb_master_tasks.svh"

  always #5 tb_hclk26 = ~tb_hclk26;         // 10 ns period

  apb_subsystem dut_i (
    .i_clk       (tb_hclk26),
    .i_rst_n     (hresetn26),
    .i_hsel      (hsel),
    .i_ahb       (ahb_req),
    .i_hwdata    (hwdata),
    .i_gpio_pin  (gpio_pin),
    .o_hrdata    (hrdata),
    .o_hready    (hready),
    .o_hresp     (hresp),
    .o_gpio_out  (gpio_out),
    .o_gpio_oe   (gpio_oe),
    .o_timer_irq (timer_irq),
    .o_gpio_irq  (gpio_irq)
  );

  // ====================================================================
  // Checks
  // ====================================================================
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act, input logic at_most);
    string bound;
    bound = at_most ? "at most " : "";
    assert (at_most ? (act <= exp) : (act === exp)) else begin
      $display("[FAIL] %s: expected %s%h, actual %h", name, bound, exp, act);
      errors++;
    end
  endtask

  function automatic logic [31:0] reg_addr(input logic [3:0] slot, input logic [5:0] off);
    return {20'd0, slot, off, 2'b00};
  endfunction

  // Output pins follow the data masked by the direction
  task automatic track_pins(input logic [31:0] addr, input logic [31:0] data, input logic resp);
    if (!resp && addr[11:8] == apb_ss_pkg::SLOT_GPIO) begin
      if (addr[7:2] == apb_ss_pkg::GPIO_OUT) model_out = data[15:0];
      if (addr[7:2] == apb_ss_pkg::GPIO_DIR) model_dir = data[15:0];
    end
    check_value($sformatf("pins after W %h", addr), {16'd0, model_out & model_dir},
                {16'd0, gpio_out}, 1'b0);
    check_value($sformatf("oe after W %h", addr), {16'd0, model_dir}, {16'd0, gpio_oe}, 1'b0);
  endtask

  // Random values through the four read-write 16-bit registers
  task automatic round_trip(input int k);
    logic [31:0] addrs [4];
    logic [31:0] rdata;
    logic        resp;
    addrs[0] = reg_addr(apb_ss_pkg::SLOT_GPIO, apb_ss_pkg::GPIO_OUT);
    addrs[1] = reg_addr(apb_ss_pkg::SLOT_GPIO, apb_ss_pkg::GPIO_DIR);
    addrs[2] = reg_addr(apb_ss_pkg::SLOT_GPIO, apb_ss_pkg::GPIO_IRQ_EN);
    addrs[3] = reg_addr(apb_ss_pkg::SLOT_TIMER, apb_ss_pkg::TMR_LOAD);
    for (int r = 0; r < 4; r++) begin
      lcg_state = lcg_next(lcg_state);
      ahb_write(addrs[r], lcg_state, resp);
      check_value($sformatf("X%0d W %h resp", k, addrs[r]), 32'd0, 32'(resp), 1'b0);
      track_pins(addrs[r], lcg_state, resp);
      ahb_read(addrs[r], rdata, resp);
      check_value($sformatf("X%0d R %h", k, addrs[r]), {16'd0, lcg_state[15:0]}, rdata, 1'b0);
      check_value($sformatf("X%0d R %h resp", k, addrs[r]), 32'd0, 32'(resp), 1'b0);
    end
  endtask

  // ====================================================================
  // Stimulus file
  // ====================================================================
  task automatic load_stimulus();
    int          fd;
    int          got;
    string       line;
    logic [7:0]  op;
    logic [31:0] a, b, c, d;
    fd = $fopen("tb/apb_subsystem_stimulus.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd) && n_ops < MAX_OPS) begin
      if ($fgets(line, fd) != 0) begin
        got = $sscanf(line, "%c %h %h %h %h", op, a, b, c, d);
        if (got == 5 && op != "#") begin   // Comments and blank lines skipped
          op_code[n_ops] = op;
          op_a[n_ops]    = a;
          op_b[n_ops]    = b;
          op_c[n_ops]    = c;
          op_d[n_ops]    = d;
          budget += 40;
          if (op == "I") budget += int'(b);
          if (op == "X") budget += int'(a) * 8 * 40;  // Eight transfers per round trip
          n_ops++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_op(input int i);
    logic [31:0] rdata;
    logic        resp;
    logic        seen;
    case (op_code[i])
      "W": begin
        ahb_write(op_a[i], op_b[i], resp);
        check_value($sformatf("W %h resp", op_a[i]), op_c[i], 32'(resp), 1'b0);
        track_pins(op_a[i], op_b[i], resp);
      end
      "R": begin
        ahb_read(op_a[i], rdata, resp);
        check_value($sformatf("R %h", op_a[i]), op_b[i], rdata, op_d[i][0]);
        check_value($sformatf("R %h resp", op_a[i]), op_c[i], 32'(resp), 1'b0);
      end
      "P": begin
        gpio_pin = op_a[i][15:0];          // Next wait counts from this change
      end
      "I": begin
        wait_irq(op_a[i][0], int'(op_b[i]), seen);
        assert (seen == op_c[i][0]) else begin
          if (op_c[i][0])
            $display("%s interrupt did not rise within %0d cycles",
                     op_a[i][0] ? "GPIO" : "Timer", op_b[i]);
          else
            $display("%s interrupt rose although it should stay low",
                     op_a[i][0] ? "GPIO" : "Timer");
          errors++;
        end
      end
      "X": for (int k = 0; k < int'(op_a[i]); k++) round_trip(k);
      default: begin
        $display("Unknown operation in stimulus line %0d", i);
        errors++;
      end
    endcase
  endtask

  // ====================================================================
  // Main sequence and watchdog
  // ====================================================================
  initial begin
    hresetn26 = 1'b0;
    hsel      = 1'b0;
    ahb_req   = '0;
    hwdata    = '0;
    gpio_pin  = '0;
    lcg_state = 32'd65981;
    model_out = '0;
    model_dir = '0;
    load_stimulus();
    budget       = budget + 10;             // Reset and slack
    budget_ready = 1'b1;
    repeat (2) @(posedge tb_hclk26);
    #1;
    hresetn26 = 1'b1;
    // Outputs straight out of reset, before any transfer
    check_value("reset hready", 32'd1, 32'(hready), 1'b0);
    check_value("reset hresp", 32'd0, 32'(hresp), 1'b0);
    check_value("reset gpio_oe", 32'd0, {16'd0, gpio_oe}, 1'b0);
    check_value("reset timer_irq", 32'd0, 32'(timer_irq), 1'b0);
    check_value("reset gpio_irq", 32'd0, 32'(gpio_irq), 1'b0);
    if (n_ops == 0) begin
      $display("Stimulus file missing or empty, nothing was run");
      errors++;
    end
    for (int i = 0; i < n_ops; i++) run_op(i);
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial begin
    wait (budget_ready);
    repeat (budget) @(posedge tb_hclk26);
    $display("Watchdog expired after %0d cycles, the run did not complete", budget);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: tb/apb_subsystem_stimulus.txt
# op a b c d, all hex: W addr data resp 0 | R addr data resp cmp (1 = at most)
# P pins 0 0 0 | I irq (0 timer, 1 gpio) cycle_limit expect | X round_trips 0 0 0
# Reset values of every register
R 00000000 00000000 0 0
R 00000004 00000000 0 0
R 00000008 00000000 0 0
R 0000000c 00000000 0 0
R 00000100 00000000 0 0
R 00000104 00000000 0 0
R 00000108 00000000 0 0
R 0000010c 00000000 0 0
R 00000110 00000000 0 0
X 00000004 0 0 0
# Pins and GPIO interrupt
W 0000010c 00000000 0 0
W 00000100 0000f0a5 0 0
W 00000104 0000ff0f 0 0
R 00000100 0000f0a5 0 0
P 00005a3c 0 0 0
I 00000001 00000006 0 0
R 00000108 00005a3c 0 0
R 00000110 00005a3c 0 0
W 00000110 0000ffff 0 0
R 00000110 00000000 0 0
W 0000010c 00000001 0 0
P 00005a3d 0 0 0
I 00000001 00000004 1 0
R 00000110 00000001 0 0
W 00000110 00000001 0 0
I 00000001 00000003 0 0
# Timer
W 00000004 00000014 0 0
W 00000000 00000003 0 0
I 00000000 0000001e 1 0
R 00000008 00000014 0 1
W 0000000c 00000001 0 0
I 00000000 00000002 0 0
I 00000000 0000001e 1 0
# Unmapped slot 2
W 00000200 deadbeef 1 0
R 00000200 00000000 1 0
R 00000000 00000003 0 0
R 00000100 0000f0a5 0 0

// File: sim.f
rtl/apb_ss_pkg.sv
rtl/ahb2apb_bridge.sv
rtl/apb_timer.sv
rtl/apb_gpio.sv
rtl/apb_subsystem.sv
+incdir+tb
tb/apb_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the subsystem testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sim.f --top-module apb_subsystem_tb -Mdir obj_dir

status=0
./obj_dir/Vapb_subsystem_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"
